//--- common/keccak_pkg.sv
// Shared Keccak-f[1600] sizes, state types, step tables and state conversions for all RTL
package keccak_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int state_width = 1600;
  localparam int lane_width  = 64;
  localparam int num_rounds  = 24;
  // Enough for indices 0..23
  localparam int round_width = 5;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [state_width-1:0] flat_state_t;
  typedef logic [lane_width-1:0] lane_t;
  // Grid indexed x, then y, then z
  typedef logic [4:0][4:0][lane_width-1:0] box_t;
  // One lane per column x
  typedef logic [4:0][lane_width-1:0] plane_t;
  typedef logic [round_width-1:0] round_t;

  ////////////////////////////////////////////////////////////
  // Step tables, indexed 5*x+y
  ////////////////////////////////////////////////////////////

  // Rho rotation per lane, Table 2 of FIPS 202 reduced mod 64
  localparam int rho_offset [25] = '{
    //  y=0  y=1  y=2  y=3  y=4
         0,  36,   3,  41,  18,  // x=0
         1,  44,  10,  45,   2,  // x=1
        62,   6,  43,  15,  61,  // x=2
        28,  55,  25,  21,  56,  // x=3
        27,  20,  39,   8,  14   // x=4
  };

  // Pi source column, (x+3y) mod 5
  // Destination (x,y) reads lane (pi_source, x)
  localparam logic [2:0] pi_source [25] = '{
    3'd0, 3'd3, 3'd1, 3'd4, 3'd2,
    3'd1, 3'd4, 3'd2, 3'd0, 3'd3,
    3'd2, 3'd0, 3'd3, 3'd1, 3'd4,
    3'd3, 3'd1, 3'd4, 3'd2, 3'd0,
    3'd4, 3'd2, 3'd0, 3'd3, 3'd1
  };

  // Iota constants, one per round
  localparam lane_t round_const [24] = '{
    64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808a, 64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808b, 64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008a, 64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009, 64'h0000_0000_8000_000a,
    64'h0000_0000_8000_808b, 64'h8000_0000_0000_008b,
    64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800a, 64'h8000_0000_8000_000a,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
  };

  ////////////////////////////////////////////////////////////
  // Conversions, lane (x,y) sits at bit 64*(5y+x)
  ////////////////////////////////////////////////////////////

  function automatic box_t to_box(flat_state_t flat);
    box_t box;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        box[x][y] = flat[lane_width*(5*y+x) +: lane_width];
      end
    end
    return box;
  endfunction

  function automatic flat_state_t to_flat(box_t box);
    flat_state_t flat;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        flat[lane_width*(5*y+x) +: lane_width] = box[x][y];
      end
    end
    return flat;
  endfunction

endpackage

//--- design/keccak_state_load.sv
// Input side of the Keccak core; holds the state and round counter, one round per clock
module keccak_state_load
  import keccak_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,
  input  flat_state_t state_i,
  input  box_t        next_state_i,
  output box_t        round_state_o,
  output round_t      round_idx_o,
  output logic        last_round_o,
  output logic        busy_o
);

  localparam round_t last_idx = round_t'(num_rounds - 1);

  box_t   state_q;
  round_t round_q;
  logic   busy_q;
  logic   start_ok;

  // Start only counts while idle
  assign start_ok = start_i && !busy_q;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      round_q <= '0;
    end else if (start_ok) begin
      busy_q  <= 1'b1;
      round_q <= '0;
    end else if (busy_q) begin
      if (round_q == last_idx) begin
        // Round 23 applied on this edge
        busy_q  <= 1'b0;
        round_q <= '0;
      end else begin
        round_q <= round_q + round_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      state_q <= to_box(state_i);
    end else if (busy_q) begin
      state_q <= next_state_i;
    end
  end

  assign round_state_o = state_q;
  assign round_idx_o   = round_q;
  // High during the cycle whose edge applies round 23
  assign last_round_o  = busy_q && (round_q == last_idx);
  assign busy_o        = busy_q;

  // Counter stays within the round table
  round_in_range_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    round_q <= last_idx);

  // Busy drops right after the last round and at no other time
  busy_after_last_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    last_round_o |=> !busy_o);
  busy_fall_cause_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(busy_o) |-> $past(last_round_o));

endmodule

//--- keccak_round/keccak_theta_rho_pi.sv
// First half of a Keccak round, combinational theta, rho and pi on the lane grid
module keccak_theta_rho_pi
  import keccak_pkg::*;
(
  input  box_t state_i,
  output box_t state_o
);

  plane_t parity;
  plane_t mix;
  box_t   theta_data;
  box_t   rho_data;

  ////////////////////////////////////////////////////////////
  // Theta
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Column parities
    for (int x = 0; x < 5; x++) begin
      parity[x] = state_i[x][0] ^ state_i[x][1] ^ state_i[x][2]
                ^ state_i[x][3] ^ state_i[x][4];
    end
    // Column x-1 plus column x+1 rotated left by one
    for (int x = 0; x < 5; x++) begin
      mix[x] = parity[(x + 4) % 5]
             ^ {parity[(x + 1) % 5][lane_width-2:0], parity[(x + 1) % 5][lane_width-1]};
    end
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        theta_data[x][y] = state_i[x][y] ^ mix[x];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Rho and pi
  ////////////////////////////////////////////////////////////

  for (genvar x = 0; x < 5; x++) begin : g_lane_x
    for (genvar y = 0; y < 5; y++) begin : g_lane_y
      localparam int rot = rho_offset[5*x+y];
      localparam int src = pi_source[5*x+y];

      logic [2*lane_width-1:0] doubled;

      // Left rotate, upper half of the shifted pair
      assign doubled = {theta_data[x][y], theta_data[x][y]} << rot;
      assign rho_data[x][y] = doubled[2*lane_width-1:lane_width];

      // Lane (x,y) takes lane (x+3y, x)
      assign state_o[x][y] = rho_data[src][x];
    end
  end

endmodule

//--- keccak_round/keccak_chi_iota.sv
// Second half of a Keccak round, combinational chi row step and iota constant
module keccak_chi_iota
  import keccak_pkg::*;
(
  input  box_t   state_i,
  input  round_t round_idx_i,
  output box_t   state_o
);

  box_t  chi_data;
  lane_t rc;

  ////////////////////////////////////////////////////////////
  // Chi
  ////////////////////////////////////////////////////////////

  // Whole sheets at a time, all five rows in parallel
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      chi_data[x] = state_i[x]
                  ^ (~state_i[(x + 1) % 5] & state_i[(x + 2) % 5]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Iota
  ////////////////////////////////////////////////////////////

  // Constant for the current round
  assign rc = round_const[round_idx_i];

  always_comb begin
    state_o       = chi_data;
    // Only lane (0,0) takes the constant
    state_o[0][0] = chi_data[0][0] ^ rc;
  end

endmodule

//--- design/keccak_result_out.sv
// Output side of the Keccak core; captures the final state and pulses done
module keccak_result_out
  import keccak_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        last_round_i,
  input  box_t        next_state_i,
  output logic        done_o,
  output flat_state_t state_o
);

  logic        done_q;
  flat_state_t result_q;

  ////////////////////////////////////////////////////////////
  // Capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      // One pulse per finished permutation
      done_q <= last_round_i;
      // Result held until the next run ends
      if (last_round_i) begin
        result_q <= to_flat(next_state_i);
      end
    end
  end

  assign done_o  = done_q;
  assign state_o = result_q;

  // Runs take 24 rounds, so done cannot repeat
  done_single_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule

//--- design/keccak_perm_top.sv
// Top of the Keccak-f[1600] core; start strobe in, done pulse and held result out
module keccak_perm_top
  import keccak_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        start_i,
  input  flat_state_t state_i,
  output logic        busy_o,
  output logic        done_o,
  output flat_state_t state_o
);

  box_t   round_state;
  round_t round_idx;
  box_t   mixed_state;
  box_t   next_state;
  logic   last_round;

  // Load and round sequencing
  keccak_state_load keccak_state_load_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .state_i       (state_i),
    .next_state_i  (next_state),
    .round_state_o (round_state),
    .round_idx_o   (round_idx),
    .last_round_o  (last_round),
    .busy_o        (busy_o)
  );

  // Linear half of the round
  keccak_theta_rho_pi keccak_theta_rho_pi_inst (
    .state_i (round_state),
    .state_o (mixed_state)
  );

  // Nonlinear half and constant
  keccak_chi_iota keccak_chi_iota_inst (
    .state_i     (mixed_state),
    .round_idx_i (round_idx),
    .state_o     (next_state)
  );

  // Result register and done pulse
  keccak_result_out keccak_result_out_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .last_round_i (last_round),
    .next_state_i (next_state),
    .done_o       (done_o),
    .state_o      (state_o)
  );

endmodule

//--- testbench/keccak_tb_tasks.svh
// Keccak reference model, drive and compare tasks and directed tests; included in the tb top
`ifndef KECCAK_TB_TASKS_SVH
`define KECCAK_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Reference model, FIPS 202 step rules
////////////////////////////////////////////////////////////

function automatic lane_t rotate_left(lane_t v, int n);
  // Shift by the full width yields zero, so n of 0 is safe
  return (v << n) | (v >> (lane_width - n));
endfunction

function automatic box_t model_round(box_t a, int r);
  plane_t c;
  box_t   b;
  box_t   e;
  for (int x = 0; x < 5; x++) begin
    c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
  end
  // Theta
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      a[x][y] ^= c[(x + 4) % 5] ^ rotate_left(c[(x + 1) % 5], 1);
    end
  end
  // Rho, then pi as a forward map (x,y) to (y, 2x+3y)
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      b[y][(2 * x + 3 * y) % 5] = rotate_left(a[x][y], rho_offset[5 * x + y]);
    end
  end
  // Chi along each row
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      e[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
    end
  end
  e[0][0] ^= round_const[r];
  return e;
endfunction

function automatic flat_state_t model_perm(flat_state_t din);
  box_t a;
  a = to_box(din);
  for (int r = 0; r < num_rounds; r++) begin
    a = model_round(a, r);
  end
  return to_flat(a);
endfunction

function automatic flat_state_t random_state();
  flat_state_t s;
  for (int i = 0; i < state_width / 32; i++) begin
    s[32 * i +: 32] = $urandom;
  end
  return s;
endfunction

////////////////////////////////////////////////////////////
// Failure and compare tasks
////////////////////////////////////////////////////////////

task automatic fail_run(string msg);
  $display("%s", msg);
  $display("sim failed");
  $fatal(1);
endtask

task automatic check_state(string name, flat_state_t exp, flat_state_t act);
  if (act !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
  end
endtask

task automatic check_lane(string name, lane_t exp, lane_t act);
  if (act !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (act !== exp) begin
    fail_run($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
  end
endtask

task automatic check_count(string name, int exp, int act);
  if (act != exp) begin
    fail_run($sformatf("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act));
  end
endtask

////////////////////////////////////////////////////////////
// Drive tasks
////////////////////////////////////////////////////////////

// Rising edge, then the drive offset
task automatic wait_cycle();
  @(posedge clk_i);
  #drive_delay;
endtask

task automatic apply_reset();
  rst_n_i = 1'b0;
  repeat (reset_cycles) @(posedge clk_i);
  #drive_delay;
  rst_n_i = 1'b1;
endtask

// Strobe for one cycle; returns just after the start edge
task automatic start_run(flat_state_t din);
  start_i = 1'b1;
  state_i = din;
  wait_cycle();
  start_i = 1'b0;
  check_bit("busy_o after start", 1'b1, busy_o);
endtask

// Busy and the held result checked every cycle until done
task automatic wait_done(output int lat);
  lat = 0;
  while (!done_o) begin
    check_bit("busy_o", 1'b1, busy_o);
    check_state("state_o held", last_result, state_o);
    wait_cycle();
    lat++;
  end
  check_bit("busy_o at done", 1'b0, busy_o);
endtask

task automatic run_and_check(flat_state_t din);
  int          lat;
  flat_state_t exp;
  exp = model_perm(din);
  start_run(din);
  wait_done(lat);
  check_count("done_o latency", exp_latency, lat);
  check_state("state_o", exp, state_o);
  last_result = exp;
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_known_answer();
  wait_cycle();
  run_and_check('0);
  // Published first lane of Keccak-f[1600] on zero input
  check_lane("state_o lane (0,0)", 64'hF125_8F79_40E1_DDE7, state_o[lane_width-1:0]);
endtask

task automatic test_random_states();
  for (int i = 0; i < 4; i++) begin
    wait_cycle();
    run_and_check(random_state());
  end
endtask

// Second start lands in the done cycle of the first run
task automatic test_back_to_back();
  wait_cycle();
  run_and_check(random_state());
  run_and_check(random_state());
endtask

task automatic test_start_while_busy();
  flat_state_t a;
  flat_state_t exp;
  int          lat;
  int          rest;
  a   = random_state();
  exp = model_perm(a);
  wait_cycle();
  start_run(a);
  lat = 0;
  repeat (10) begin
    wait_cycle();
    lat++;
  end
  // Different data mid-run, one cycle strobe
  start_i = 1'b1;
  state_i = random_state();
  wait_cycle();
  lat++;
  start_i = 1'b0;
  wait_done(rest);
  check_count("done_o latency with busy start", exp_latency, lat + rest);
  check_state("state_o after busy start", exp, state_o);
  last_result = exp;
endtask

task automatic test_reset_mid_run();
  wait_cycle();
  start_run(random_state());
  repeat (8) wait_cycle();
  apply_reset();
  last_result = '0;
  // Aborted run must never finish
  repeat (run_cycles) begin
    check_bit("busy_o after reset", 1'b0, busy_o);
    check_bit("done_o after reset", 1'b0, done_o);
    check_state("state_o after reset", last_result, state_o);
    wait_cycle();
  end
endtask

`endif

//--- testbench/keccak_perm_tb.sv
// Testbench top for the Keccak-f[1600] core; clock, reset, DUT, timeout and test sequence
module keccak_perm_tb
  import keccak_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // Timing
  ////////////////////////////////////////////////////////////

  localparam int clk_half     = 20;
  localparam int drive_delay  = 5;
  localparam int reset_cycles = 4;
  // About 30 cycles per permutation, ten permutations, plus margin
  localparam int run_cycles     = 30;
  localparam int num_runs       = 10;
  localparam int timeout_cycles = run_cycles * num_runs + 100;
  // Start edge to done, one edge per round
  localparam int exp_latency = num_rounds;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic        clk_i;
  logic        rst_n_i;
  logic        start_i;
  flat_state_t state_i;
  logic        busy_o;
  logic        done_o;
  flat_state_t state_o;

  // Result that state_o should hold between runs
  flat_state_t last_result;
  int          cycle_count;

  keccak_perm_top keccak_perm_top_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_i),
    .state_i (state_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .state_o (state_o)
  );

  // Model, drive tasks, compare tasks and tests
  `include "keccak_tb_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////////////////////////

  always #clk_half clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("Timeout: no finish after %0d clock cycles", cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    // Single seed for the whole run
    void'($urandom(35891));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    state_i     = '0;
    last_result = '0;
    cycle_count = 0;

    apply_reset();

    test_known_answer();
    test_random_states();
    test_back_to_back();
    test_start_while_busy();
    test_reset_mid_run();

    $display("sim passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
common/keccak_pkg.sv
design/keccak_state_load.sv
keccak_round/keccak_theta_rho_pi.sv
keccak_round/keccak_chi_iota.sv
design/keccak_result_out.sv
design/keccak_perm_top.sv
testbench/keccak_perm_tb.sv

//--- Makefile
# Verilator build and run for the Keccak-f[1600] core

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= keccak_perm_tb
RTL_TOP   ?= keccak_perm_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation OK"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
